/* hdl/ao_periph_pkg.sv */
/*
 * Always-on peripheral subsystem definitions
 * Bus widths, address map, register offsets and byte-strobe merge
 */
package ao_periph_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = 4;

  // Peripheral slots behind the demux
  localparam int unsigned NUM_PERIPH = 3;
  localparam int unsigned SOC_CTRL_IDX = 0;
  localparam int unsigned TIMER_IDX = 1;
  localparam int unsigned GPIO_IDX = 2;
  localparam int unsigned SEL_W = 2;

  // Address bits 15:12 pick the region
  localparam int unsigned REGION_LSB = 12;
  localparam int unsigned REGION_W = 4;

  localparam logic [7:0] SOC_CTRL_EXIT_VALID_OFS = 8'h00;
  localparam logic [7:0] SOC_CTRL_EXIT_VALUE_OFS = 8'h04;
  localparam logic [7:0] SOC_CTRL_BOOT_SEL_OFS = 8'h08;
  localparam logic [7:0] SOC_CTRL_SCRATCH_OFS = 8'h0C;

  localparam logic [7:0] TIMER_CTRL_OFS = 8'h00;
  localparam logic [7:0] TIMER_COUNT_OFS = 8'h04;
  localparam logic [7:0] TIMER_COMPARE_OFS = 8'h08;
  localparam logic [7:0] TIMER_INTR_OFS = 8'h0C;

  localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
  localparam logic [7:0] GPIO_OUT_EN_OFS = 8'h04;
  localparam logic [7:0] GPIO_IN_OFS = 8'h08;
  localparam logic [7:0] GPIO_INTR_EN_OFS = 8'h0C;
  localparam logic [7:0] GPIO_INTR_STATUS_OFS = 8'h10;

  localparam int unsigned GPIO_W = 8;

  // Replace only the bytes whose strobe is set
  function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] cur,
                                                   input logic [DATA_W-1:0] wdata,
                                                   input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = cur;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i+:8] = wdata[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage

/* hdl/reg_bus_if.sv */
/*
 * Register bus with valid/ready exchange
 * Slaves answer in the same cycle as the request
 */
`timescale 1ns/1ps

interface reg_bus_if
  import ao_periph_pkg::*;
();

  logic              valid;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic [DATA_W-1:0] rdata;
  logic              error;
  logic              ready;

  modport master (
    output valid,
    output write,
    output addr,
    output wdata,
    output wstrb,
    input  rdata,
    input  error,
    input  ready
  );

  modport slave (
    input  valid,
    input  write,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata,
    output error,
    output ready
  );

endinterface

/* hdl/obi_reg_bridge.sv */
/*
 * OBI host port to register bus bridge
 * Grants on bus ready and returns the response one cycle later
 */
`timescale 1ns/1ps

module obi_reg_bridge
  import ao_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,

  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] be_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,

  reg_bus_if.master         bus_o
);

  // Request goes straight onto the register bus
  assign bus_o.valid = req_i;
  assign bus_o.write = we_i;
  assign bus_o.addr  = addr_i;
  assign bus_o.wdata = wdata_i;
  assign bus_o.wstrb = be_i;

  assign gnt_o = req_i & bus_o.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= gnt_o;
      err_o    <= gnt_o & bus_o.error;
    end
  end

  // Read data captured with the grant
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_o <= bus_o.rdata;
    end
  end

endmodule

/* hdl/periph_reg_demux.sv */
/*
 * Register bus demultiplexer for the always-on peripherals
 * Unmapped regions are answered with an error and zero data
 */
`timescale 1ns/1ps

module periph_reg_demux
  import ao_periph_pkg::*;
(
  reg_bus_if.slave  bus_i,
  reg_bus_if.master soc_ctrl_o,
  reg_bus_if.master timer_o,
  reg_bus_if.master gpio_o
);

  logic [REGION_W-1:0] region;
  logic [SEL_W-1:0]    sel;
  logic                hit;

  assign region = bus_i.addr[REGION_LSB+:REGION_W];
  assign sel    = region[SEL_W-1:0];

  // Upper address bits must be clear for a hit
  assign hit = (bus_i.addr[ADDR_W-1:REGION_LSB+REGION_W] == '0) &&
               (region < REGION_W'(NUM_PERIPH));

  assign soc_ctrl_o.valid = bus_i.valid & hit & (sel == SEL_W'(SOC_CTRL_IDX));
  assign soc_ctrl_o.write = bus_i.write;
  assign soc_ctrl_o.addr  = bus_i.addr;
  assign soc_ctrl_o.wdata = bus_i.wdata;
  assign soc_ctrl_o.wstrb = bus_i.wstrb;

  assign timer_o.valid = bus_i.valid & hit & (sel == SEL_W'(TIMER_IDX));
  assign timer_o.write = bus_i.write;
  assign timer_o.addr  = bus_i.addr;
  assign timer_o.wdata = bus_i.wdata;
  assign timer_o.wstrb = bus_i.wstrb;

  assign gpio_o.valid = bus_i.valid & hit & (sel == SEL_W'(GPIO_IDX));
  assign gpio_o.write = bus_i.write;
  assign gpio_o.addr  = bus_i.addr;
  assign gpio_o.wdata = bus_i.wdata;
  assign gpio_o.wstrb = bus_i.wstrb;

  always_comb begin
    bus_i.rdata = '0;
    bus_i.error = 1'b1;
    bus_i.ready = 1'b1;
    if (hit) begin
      bus_i.error = 1'b0;
      case (sel)
        SEL_W'(SOC_CTRL_IDX): begin
          bus_i.rdata = soc_ctrl_o.rdata;
          bus_i.error = soc_ctrl_o.error;
          bus_i.ready = soc_ctrl_o.ready;
        end
        SEL_W'(TIMER_IDX): begin
          bus_i.rdata = timer_o.rdata;
          bus_i.error = timer_o.error;
          bus_i.ready = timer_o.ready;
        end
        SEL_W'(GPIO_IDX): begin
          bus_i.rdata = gpio_o.rdata;
          bus_i.error = gpio_o.error;
          bus_i.ready = gpio_o.ready;
        end
        default: ;
      endcase
    end
  end

endmodule

/* hdl/soc_ctrl.sv */
/*
 * SoC control registers
 * Exit flag and value, boot-select readback and scratch
 */
`timescale 1ns/1ps

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  reg_bus_if.slave          bus_i,
  input  logic              boot_select_i,
  input  logic              execute_from_flash_i,
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o
);

  logic [DATA_W-1:0] scratch_q;
  logic [7:0]        ofs;
  logic              we;

  assign ofs = bus_i.addr[7:0];
  assign we  = bus_i.valid & bus_i.write;

  assign bus_i.ready = 1'b1;
  assign bus_i.error = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      scratch_q    <= '0;
    end else if (we) begin
      if (ofs == SOC_CTRL_EXIT_VALID_OFS && bus_i.wstrb[0]) begin
        exit_valid_o <= bus_i.wdata[0];
      end
      if (ofs == SOC_CTRL_EXIT_VALUE_OFS) begin
        exit_value_o <= strb_merge(exit_value_o, bus_i.wdata, bus_i.wstrb);
      end
      if (ofs == SOC_CTRL_SCRATCH_OFS) begin
        scratch_q <= strb_merge(scratch_q, bus_i.wdata, bus_i.wstrb);
      end
    end
  end

  always_comb begin
    bus_i.rdata = '0;
    case (ofs)
      SOC_CTRL_EXIT_VALID_OFS: bus_i.rdata = {{(DATA_W-1){1'b0}}, exit_valid_o};
      SOC_CTRL_EXIT_VALUE_OFS: bus_i.rdata = exit_value_o;
      SOC_CTRL_BOOT_SEL_OFS:
        bus_i.rdata = {{(DATA_W-2){1'b0}}, execute_from_flash_i, boot_select_i};
      SOC_CTRL_SCRATCH_OFS:    bus_i.rdata = scratch_q;
      default: ;
    endcase
  end

endmodule

/* hdl/ao_timer.sv */
/*
 * Always-on compare timer
 * Counter wraps on compare match and sets a sticky interrupt
 */
`timescale 1ns/1ps

module ao_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  reg_bus_if.slave bus_i,
  output logic     timer_intr_o
);

  logic              enable_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] compare_q;
  logic              pending_q;
  logic [7:0]        ofs;
  logic              we;
  logic              match;

  assign ofs   = bus_i.addr[7:0];
  assign we    = bus_i.valid & bus_i.write;
  assign match = enable_q && (count_q == compare_q);

  assign bus_i.ready = 1'b1;
  assign bus_i.error = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      pending_q <= 1'b0;
    end else begin
      if (we && ofs == TIMER_CTRL_OFS && bus_i.wstrb[0]) begin
        enable_q <= bus_i.wdata[0];
      end
      if (we && ofs == TIMER_COMPARE_OFS) begin
        compare_q <= strb_merge(compare_q, bus_i.wdata, bus_i.wstrb);
      end
      // Bus write wins over the increment
      if (we && ofs == TIMER_COUNT_OFS) begin
        count_q <= strb_merge(count_q, bus_i.wdata, bus_i.wstrb);
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + DATA_W'(1);
      end
      // A new match beats a clear in the same cycle
      if (match) begin
        pending_q <= 1'b1;
      end else if (we && ofs == TIMER_INTR_OFS && bus_i.wstrb[0] && bus_i.wdata[0]) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_comb begin
    bus_i.rdata = '0;
    case (ofs)
      TIMER_CTRL_OFS:    bus_i.rdata = {{(DATA_W-1){1'b0}}, enable_q};
      TIMER_COUNT_OFS:   bus_i.rdata = count_q;
      TIMER_COMPARE_OFS: bus_i.rdata = compare_q;
      TIMER_INTR_OFS:    bus_i.rdata = {{(DATA_W-1){1'b0}}, pending_q};
      default: ;
    endcase
  end

  assign timer_intr_o = pending_q;

endmodule

/* hdl/gpio_ao.sv */
/*
 * Always-on GPIO block
 * Output and enable registers, synchronized inputs, rising-edge interrupts
 */
`timescale 1ns/1ps

module gpio_ao
  import ao_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  reg_bus_if.slave          bus_i,
  input  logic [GPIO_W-1:0] cio_gpio_i,
  output logic [GPIO_W-1:0] cio_gpio_o,
  output logic [GPIO_W-1:0] cio_gpio_en_o,
  output logic [GPIO_W-1:0] intr_gpio_o
);

  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] status_q;
  logic [GPIO_W-1:0] sync_q;
  logic [GPIO_W-1:0] in_q;
  logic [GPIO_W-1:0] in_prev_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] clr;
  logic [7:0]        ofs;
  logic              we;

  assign ofs  = bus_i.addr[7:0];
  assign we   = bus_i.valid & bus_i.write & bus_i.wstrb[0];
  assign rise = in_q & ~in_prev_q;
  assign clr  = (we && ofs == GPIO_INTR_STATUS_OFS) ? bus_i.wdata[GPIO_W-1:0] : '0;

  assign bus_i.ready = 1'b1;
  assign bus_i.error = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cio_gpio_o    <= '0;
      cio_gpio_en_o <= '0;
      intr_en_q     <= '0;
      status_q      <= '0;
      sync_q        <= '0;
      in_q          <= '0;
      in_prev_q     <= '0;
    end else begin
      // Two-flop synchronizer and edge history
      sync_q    <= cio_gpio_i;
      in_q      <= sync_q;
      in_prev_q <= in_q;
      status_q  <= (status_q & ~clr) | rise;
      if (we && ofs == GPIO_OUT_OFS)     cio_gpio_o    <= bus_i.wdata[GPIO_W-1:0];
      if (we && ofs == GPIO_OUT_EN_OFS)  cio_gpio_en_o <= bus_i.wdata[GPIO_W-1:0];
      if (we && ofs == GPIO_INTR_EN_OFS) intr_en_q     <= bus_i.wdata[GPIO_W-1:0];
    end
  end

  always_comb begin
    bus_i.rdata = '0;
    case (ofs)
      GPIO_OUT_OFS:         bus_i.rdata = {{(DATA_W-GPIO_W){1'b0}}, cio_gpio_o};
      GPIO_OUT_EN_OFS:      bus_i.rdata = {{(DATA_W-GPIO_W){1'b0}}, cio_gpio_en_o};
      GPIO_IN_OFS:          bus_i.rdata = {{(DATA_W-GPIO_W){1'b0}}, in_q};
      GPIO_INTR_EN_OFS:     bus_i.rdata = {{(DATA_W-GPIO_W){1'b0}}, intr_en_q};
      GPIO_INTR_STATUS_OFS: bus_i.rdata = {{(DATA_W-GPIO_W){1'b0}}, status_q};
      default: ;
    endcase
  end

  assign intr_gpio_o = status_q & intr_en_q;

endmodule

/* hdl/ao_peripheral_subsystem.sv */
/*
 * Always-on peripheral subsystem top level
 * Host bridge, region demux, SoC control, timer and GPIO
 */
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,

  // Host port
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] be_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,

  // SoC control
  input  logic              boot_select_i,
  input  logic              execute_from_flash_i,
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o,

  output logic              timer_intr_o,

  // GPIO
  input  logic [GPIO_W-1:0] cio_gpio_i,
  output logic [GPIO_W-1:0] cio_gpio_o,
  output logic [GPIO_W-1:0] cio_gpio_en_o,
  output logic [GPIO_W-1:0] intr_gpio_o
);

  reg_bus_if periph_bus ();
  reg_bus_if soc_ctrl_bus ();
  reg_bus_if timer_bus ();
  reg_bus_if gpio_bus ();

  obi_reg_bridge i_obi_reg_bridge (
    .clk_i,
    .arst_n_i,
    .req_i,
    .addr_i,
    .we_i,
    .wdata_i,
    .be_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .bus_o    (periph_bus.master)
  );

  periph_reg_demux i_periph_reg_demux (
    .bus_i      (periph_bus.slave),
    .soc_ctrl_o (soc_ctrl_bus.master),
    .timer_o    (timer_bus.master),
    .gpio_o     (gpio_bus.master)
  );

  soc_ctrl i_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .bus_i                (soc_ctrl_bus.slave),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  ao_timer i_ao_timer (
    .clk_i,
    .arst_n_i,
    .bus_i        (timer_bus.slave),
    .timer_intr_o
  );

  gpio_ao i_gpio_ao (
    .clk_i,
    .arst_n_i,
    .bus_i         (gpio_bus.slave),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule

/* tb/ao_periph_assertions.sv */
/*
 * Host port protocol assertions for the peripheral subsystem
 */
`timescale 1ns/1ps

module ao_periph_assertions (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic err_i
);

  // Response exactly one cycle after each grant
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_i |=> rvalid_i)
    else $error("rvalid_o did not follow a grant");

  no_rvalid_without_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !gnt_i |=> !rvalid_i)
    else $error("rvalid_o without a grant in the cycle before");

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_i |-> req_i)
    else $error("gnt_o high without req_i");

  err_needs_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_i |-> rvalid_i)
    else $error("err_o high without rvalid_o");

endmodule

bind ao_peripheral_subsystem ao_periph_assertions i_ao_periph_assertions (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .req_i    (req_i),
  .gnt_i    (gnt_o),
  .rvalid_i (rvalid_o),
  .err_i    (err_o)
);

/* tb/tb_ao_peripheral_subsystem.sv */
/*
 * Random-stimulus testbench for the always-on peripheral subsystem
 * Register model, host port tasks, watchdog and final report
 */
`timescale 1ns/1ps

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  localparam int N_RAND_WR = 200;
  localparam int N_ERR = 30;
  localparam int TIMER_ROUNDS = 3;
  localparam int N_GPIO = 20;
  localparam int N_B2B = 20;
  localparam int GNT_TIMEOUT = 20;
  localparam int TXN_TOTAL = 13 + 2*N_RAND_WR + N_ERR + 6 + 7*TIMER_ROUNDS + 2 + 5*N_GPIO + N_B2B;
  localparam int WATCHDOG_CYCLES = 16 + TXN_TOTAL*20 + TIMER_ROUNDS*(50+5);

  logic              clk_i;
  logic              arst_n_i;
  logic              req_i;
  logic [ADDR_W-1:0] addr_i;
  logic              we_i;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] be_i;
  logic              gnt_o;
  logic              rvalid_o;
  logic [DATA_W-1:0] rdata_o;
  logic              err_o;
  logic              boot_select_i;
  logic              execute_from_flash_i;
  logic              exit_valid_o;
  logic [DATA_W-1:0] exit_value_o;
  logic              timer_intr_o;
  logic [GPIO_W-1:0] cio_gpio_i;
  logic [GPIO_W-1:0] cio_gpio_o;
  logic [GPIO_W-1:0] cio_gpio_en_o;
  logic [GPIO_W-1:0] intr_gpio_o;

  // Register model
  logic              m_exit_valid;
  logic [DATA_W-1:0] m_exit_value;
  logic [DATA_W-1:0] m_scratch;
  logic [GPIO_W-1:0] m_out;
  logic [GPIO_W-1:0] m_oe;
  logic [GPIO_W-1:0] m_ie;
  logic [GPIO_W-1:0] m_status;
  logic [GPIO_W-1:0] m_in;

  logic [ADDR_W-1:0] targets [7];
  logic [ADDR_W-1:0] b2b_addr;
  logic [DATA_W-1:0] b2b_exp [N_B2B];
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] cmp;
  logic [STRB_W-1:0] be;
  logic [GPIO_W-1:0] pat;
  logic              err;
  logic              we;
  int                waited;
  int                responses;
  int                checks;
  int                errors;

  ao_peripheral_subsystem i_ao_peripheral_subsystem (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [ADDR_W-1:0] reg_addr(input int unsigned idx, input logic [7:0] ofs);
    return (32'(idx) << REGION_LSB) | 32'(ofs);
  endfunction

  function automatic logic [DATA_W-1:0] byte_mask(input logic [STRB_W-1:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  // Expected read data with the timer reading zero outside its own test
  function automatic logic [DATA_W-1:0] exp_read(input logic [ADDR_W-1:0] a);
    case (a)
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_EXIT_VALID_OFS): return {31'b0, m_exit_valid};
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_EXIT_VALUE_OFS): return m_exit_value;
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_BOOT_SEL_OFS):
        return {30'b0, execute_from_flash_i, boot_select_i};
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_SCRATCH_OFS): return m_scratch;
      reg_addr(GPIO_IDX, GPIO_OUT_OFS): return {24'b0, m_out};
      reg_addr(GPIO_IDX, GPIO_OUT_EN_OFS): return {24'b0, m_oe};
      reg_addr(GPIO_IDX, GPIO_IN_OFS): return {24'b0, m_in};
      reg_addr(GPIO_IDX, GPIO_INTR_EN_OFS): return {24'b0, m_ie};
      reg_addr(GPIO_IDX, GPIO_INTR_STATUS_OFS): return {24'b0, m_status};
      default: return '0;
    endcase
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    mask = byte_mask(strb);
    case (a)
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_EXIT_VALID_OFS): if (strb[0]) m_exit_valid = d[0];
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_EXIT_VALUE_OFS):
        m_exit_value = (m_exit_value & ~mask) | (d & mask);
      reg_addr(SOC_CTRL_IDX, SOC_CTRL_SCRATCH_OFS): m_scratch = (m_scratch & ~mask) | (d & mask);
      reg_addr(GPIO_IDX, GPIO_OUT_OFS): if (strb[0]) m_out = d[7:0];
      reg_addr(GPIO_IDX, GPIO_OUT_EN_OFS): if (strb[0]) m_oe = d[7:0];
      reg_addr(GPIO_IDX, GPIO_INTR_EN_OFS): if (strb[0]) m_ie = d[7:0];
      reg_addr(GPIO_IDX, GPIO_INTR_STATUS_OFS): if (strb[0]) m_status = m_status & ~d[7:0];
      default: ;
    endcase
  endtask

  task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // One host access that returns at the falling edge after the response
  task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] strb,
                            output logic [DATA_W-1:0] rd, output logic rerr);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= wr;
    addr_i  <= a;
    wdata_i <= d;
    be_i    <= strb;
    @(negedge clk_i);
    while (!gnt_o && cnt < GNT_TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!gnt_o) begin
      errors++;
      $display("error: no grant for address %h within %0d cycles", a, GNT_TIMEOUT);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    if (!rvalid_o) begin
      errors++;
      $display("error: no response one cycle after the grant for address %h", a);
    end
    rd   = rdata_o;
    rerr = err_o;
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                           input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] rd;
    logic              rerr;
    bus_access(1'b1, a, d, strb, rd, rerr);
    check_value($sformatf("write error flag at %h", a), 32'(rerr), 32'd0);
    model_write(a, d, strb);
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] rd;
    logic              rerr;
    bus_access(1'b0, a, '0, 4'hF, rd, rerr);
    check_value($sformatf("read error flag at %h", a), 32'(rerr), 32'd0);
    check_value($sformatf("read data at %h", a), rd, exp_read(a));
  endtask

  task automatic check_outputs();
    check_value("exit_valid_o", 32'(exit_valid_o), 32'(m_exit_valid));
    check_value("exit_value_o", exit_value_o, m_exit_value);
    check_value("cio_gpio_o", 32'(cio_gpio_o), 32'(m_out));
    check_value("cio_gpio_en_o", 32'(cio_gpio_en_o), 32'(m_oe));
    check_value("intr_gpio_o", 32'(intr_gpio_o), 32'(m_status & m_ie));
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d errors so far", name, errors);
  endtask

  initial begin
    void'($urandom(32'h36a3_45c1));
    arst_n_i             = 1'b0;
    req_i                = 1'b0;
    addr_i               = '0;
    we_i                 = 1'b0;
    wdata_i              = '0;
    be_i                 = '0;
    cio_gpio_i           = '0;
    boot_select_i        = 1'($urandom);
    execute_from_flash_i = 1'($urandom);
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_scratch    = '0;
    m_out        = '0;
    m_oe         = '0;
    m_ie         = '0;
    m_status     = '0;
    m_in         = '0;
    checks       = 0;
    errors       = 0;
    targets[0] = reg_addr(SOC_CTRL_IDX, SOC_CTRL_SCRATCH_OFS);
    targets[1] = reg_addr(SOC_CTRL_IDX, SOC_CTRL_EXIT_VALUE_OFS);
    targets[2] = reg_addr(SOC_CTRL_IDX, SOC_CTRL_EXIT_VALID_OFS);
    targets[3] = reg_addr(GPIO_IDX, GPIO_OUT_OFS);
    targets[4] = reg_addr(GPIO_IDX, GPIO_OUT_EN_OFS);
    targets[5] = reg_addr(GPIO_IDX, GPIO_INTR_EN_OFS);
    targets[6] = reg_addr(SOC_CTRL_IDX, SOC_CTRL_BOOT_SEL_OFS);

    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);

    check_value("rvalid_o after reset", 32'(rvalid_o), 32'd0);
    check_value("err_o after reset", 32'(err_o), 32'd0);
    check_value("timer_intr_o after reset", 32'(timer_intr_o), 32'd0);
    check_outputs();
    for (int idx = 0; idx < NUM_PERIPH; idx++) begin
      for (int ofs = 0; ofs <= ((idx == GPIO_IDX) ? 16 : 12); ofs += 4) begin
        read_check(reg_addr(idx, 8'(ofs)));
      end
    end
    report_test("reset");

    for (int i = 0; i < N_RAND_WR; i++) begin
      addr = targets[$urandom_range(0, 5)];
      data = $urandom;
      be   = STRB_W'($urandom);
      write_reg(addr, data, be);
      check_outputs();
      read_check(addr);
    end
    report_test("random_write");

    for (int i = 0; i < N_ERR; i++) begin
      if ($urandom_range(0, 1) == 0) begin
        addr = {16'h0, 4'(3 + $urandom_range(0, 12)), 12'($urandom)};
      end else begin
        addr = {16'($urandom_range(1, 16'hFFFF)), 16'($urandom)};
      end
      we = 1'($urandom);
      bus_access(we, addr, $urandom, STRB_W'($urandom), rdata, err);
      check_value($sformatf("unmapped error flag at %h", addr), 32'(err), 32'd1);
      check_value($sformatf("unmapped data at %h", addr), rdata, 32'd0);
    end
    for (int i = 0; i < 6; i++) begin
      read_check(targets[i]);
    end
    report_test("unmapped");

    for (int r = 0; r < TIMER_ROUNDS; r++) begin
      cmp = 2 + $urandom_range(0, 48);
      write_reg(reg_addr(TIMER_IDX, TIMER_COMPARE_OFS), cmp, 4'hF);
      write_reg(reg_addr(TIMER_IDX, TIMER_COUNT_OFS), 32'd0, 4'hF);
      write_reg(reg_addr(TIMER_IDX, TIMER_CTRL_OFS), 32'd1, 4'h1);
      waited = 0;
      while (!timer_intr_o && waited < int'(cmp) + 5) begin
        @(negedge clk_i);
        waited++;
      end
      if (!timer_intr_o) begin
        errors++;
        $display("error: timer interrupt did not rise within %0d cycles", cmp + 5);
      end
      write_reg(reg_addr(TIMER_IDX, TIMER_CTRL_OFS), 32'd0, 4'h1);
      write_reg(reg_addr(TIMER_IDX, TIMER_INTR_OFS), 32'd1, 4'h1);
      read_check(reg_addr(TIMER_IDX, TIMER_INTR_OFS));
      check_value("timer_intr_o after clear", 32'(timer_intr_o), 32'd0);
      bus_access(1'b0, reg_addr(TIMER_IDX, TIMER_COMPARE_OFS), '0, 4'hF, rdata, err);
      check_value("timer compare readback", rdata, cmp);
    end
    report_test("timer");

    write_reg(reg_addr(GPIO_IDX, GPIO_INTR_EN_OFS), $urandom, 4'h1);
    write_reg(reg_addr(GPIO_IDX, GPIO_INTR_STATUS_OFS), 32'hFF, 4'h1);
    for (int i = 0; i < N_GPIO; i++) begin
      pat = GPIO_W'($urandom);
      @(posedge clk_i);
      cio_gpio_i <= pat;
      // Rising edges accumulate into the status
      m_status = m_status | (pat & ~m_in);
      m_in     = pat;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      read_check(reg_addr(GPIO_IDX, GPIO_IN_OFS));
      read_check(reg_addr(GPIO_IDX, GPIO_INTR_STATUS_OFS));
      check_outputs();
      if (i % 4 == 3) begin
        write_reg(reg_addr(GPIO_IDX, GPIO_INTR_STATUS_OFS), $urandom, STRB_W'($urandom));
        read_check(reg_addr(GPIO_IDX, GPIO_INTR_STATUS_OFS));
        check_outputs();
      end
    end
    report_test("gpio");

    // req_i stays high with one response per grant
    responses = 0;
    for (int i = 0; i <= N_B2B; i++) begin
      @(posedge clk_i);
      if (i < N_B2B) begin
        b2b_addr   = targets[$urandom_range(0, 6)];
        b2b_exp[i] = exp_read(b2b_addr);
        req_i  <= 1'b1;
        we_i   <= 1'b0;
        addr_i <= b2b_addr;
        be_i   <= 4'hF;
      end else begin
        req_i <= 1'b0;
      end
      @(negedge clk_i);
      if (i < N_B2B) begin
        check_value("back-to-back grant", 32'(gnt_o), 32'd1);
      end
      if (i > 0) begin
        check_value("back-to-back rvalid", 32'(rvalid_o), 32'd1);
        check_value($sformatf("back-to-back data %0d", i - 1), rdata_o, b2b_exp[i-1]);
        if (rvalid_o) responses++;
      end
    end
    check_value("back-to-back response count", 32'(responses), 32'(N_B2B));
    report_test("back_to_back");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/ao_periph_pkg.sv
hdl/reg_bus_if.sv
hdl/obi_reg_bridge.sv
hdl/periph_reg_demux.sv
hdl/soc_ctrl.sv
hdl/ao_timer.sv
hdl/gpio_ao.sv
hdl/ao_peripheral_subsystem.sv
tb/ao_periph_assertions.sv
tb/tb_ao_peripheral_subsystem.sv

/* Makefile */
TOP := tb_ao_peripheral_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
